/* hdl/rsPkg.sv */
package rsPkg;

    localparam int DATA_WIDTH = 32;
    localparam int TAG_WIDTH = 7;
    localparam int MAX_ENTRIES = 32; // upper bound for NUM_ENTRIES
    localparam int IDX_MAX_W = $clog2(MAX_ENTRIES);

    typedef struct packed {
        logic memToReg;
        logic memRead;
        logic memWrite;
        logic aluSrc1;
        logic aluSrc2;
        logic jump;
        logic branch;
        logic [3:0] aluOp;
        logic [2:0] funct3;
    } rsCtrl_t;

    typedef struct packed {
        logic [TAG_WIDTH-1:0] tag;
        logic [DATA_WIDTH-1:0] data;
        logic valid; // data holds the operand value
    } rsOperand_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] pc;
        logic [TAG_WIDTH-1:0] dest;
        rsCtrl_t ctrl;
        logic [DATA_WIDTH-1:0] imm;
        rsOperand_t src1;
        rsOperand_t src2;
    } rsEntry_t;

    typedef struct packed {
        logic valid;
        logic [TAG_WIDTH-1:0] tag;
        logic [DATA_WIDTH-1:0] data;
    } rsBus_t;

    function automatic logic [IDX_MAX_W-1:0] lowestSet(logic [MAX_ENTRIES-1:0] mask);
        logic [IDX_MAX_W-1:0] idx;
        idx = '0;
        for (int i = MAX_ENTRIES - 1; i >= 0; i--) begin
            if (mask[i]) idx = IDX_MAX_W'(i); // last hit is the lowest
        end
        return idx;
    endfunction

    // take bus data when a waiting operand sees its tag
    function automatic rsOperand_t snoopBus(rsOperand_t op, rsBus_t bus);
        rsOperand_t res;
        res = op;
        if (bus.valid && !op.valid && bus.tag == op.tag) begin
            res.data = bus.data;
            res.valid = 1'b1;
        end
        return res;
    endfunction

endpackage

/* hdl/rsAllocIf.sv */
interface rsAllocIf import rsPkg::*; #(
    parameter int NUM_ENTRIES = 8
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    logic allocFire;
    logic [IDX_W-1:0] allocIndex;
    rsEntry_t allocEntry;
    logic [NUM_ENTRIES-1:0] freeMask;

    modport dispatch (
        output allocFire,
        output allocIndex,
        output allocEntry,
        input freeMask
    );

    modport storage (
        input allocFire,
        input allocIndex,
        input allocEntry,
        output freeMask
    );

endinterface

/* hdl/rsIssueIf.sv */
interface rsIssueIf import rsPkg::*; #(
    parameter int NUM_ENTRIES = 8
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    logic [NUM_ENTRIES-1:0] readyMask;
    rsEntry_t grantEntry; // entry at grantIndex
    logic grantFire;
    logic [IDX_W-1:0] grantIndex;

    modport storage (
        output readyMask,
        output grantEntry,
        input grantFire,
        input grantIndex
    );

    modport select (
        input readyMask,
        input grantEntry,
        output grantFire,
        output grantIndex
    );

endinterface

/* hdl/rsDispatch.sv */
module rsDispatch import rsPkg::*; #(
    parameter int NUM_ENTRIES = 8,
    parameter int NUM_BUSES = 4
) (
    input logic clk,
    input logic reset,
    input logic dispatchValid,
    output logic dispatchReady,
    input logic [DATA_WIDTH-1:0] dispatchPc,
    input logic [TAG_WIDTH-1:0] dispatchDest,
    input rsCtrl_t dispatchCtrl,
    input logic [DATA_WIDTH-1:0] dispatchImm,
    input rsOperand_t src1,
    input rsOperand_t src2,
    input rsBus_t buses [NUM_BUSES],
    rsAllocIf.dispatch alloc
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    rsOperand_t op1;
    rsOperand_t op2;

    assign dispatchReady = |alloc.freeMask; // any free slot
    assign alloc.allocFire = dispatchValid && dispatchReady;
    assign alloc.allocIndex = IDX_W'(lowestSet(MAX_ENTRIES'(alloc.freeMask)));

    // same-cycle bypass from the result buses
    always_comb begin
        op1 = src1;
        op2 = src2;
        for (int b = 0; b < NUM_BUSES; b++) begin
            op1 = snoopBus(op1, buses[b]);
            op2 = snoopBus(op2, buses[b]);
        end
    end

    always_comb begin
        alloc.allocEntry.pc = dispatchPc;
        alloc.allocEntry.dest = dispatchDest;
        alloc.allocEntry.ctrl = dispatchCtrl;
        alloc.allocEntry.imm = dispatchImm;
        alloc.allocEntry.src1 = op1;
        alloc.allocEntry.src2 = op2;
    end

    // the slot handed to the table is taken there after the edge
    assert property (@(posedge clk) disable iff (reset)
        alloc.allocFire |=> !alloc.freeMask[$past(alloc.allocIndex)])
        else $error("slot %0d still free after alloc", $past(alloc.allocIndex));

endmodule

/* hdl/rsEntryTable.sv */
module rsEntryTable import rsPkg::*; #(
    parameter int NUM_ENTRIES = 8,
    parameter int NUM_BUSES = 4
) (
    input logic clk,
    input logic reset,
    input rsBus_t buses [NUM_BUSES],
    rsAllocIf.storage alloc,
    rsIssueIf.storage issue
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    rsEntry_t entries [NUM_ENTRIES];
    rsEntry_t woken [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] busy;
    logic [NUM_ENTRIES-1:0] allocHit;
    logic [NUM_ENTRIES-1:0] grantHit;

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            allocHit[i] = alloc.allocFire && alloc.allocIndex == IDX_W'(i);
            grantHit[i] = issue.grantFire && issue.grantIndex == IDX_W'(i);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= '0;
        end else begin
            busy <= (busy | allocHit) & ~grantHit; // alloc and grant never share a slot
        end
    end

    // tag match against every bus
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            woken[i] = entries[i];
            for (int b = 0; b < NUM_BUSES; b++) begin
                woken[i].src1 = snoopBus(woken[i].src1, buses[b]);
                woken[i].src2 = snoopBus(woken[i].src2, buses[b]);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (allocHit[i]) begin
                entries[i] <= alloc.allocEntry;
            end else if (busy[i]) begin
                entries[i] <= woken[i];
            end
        end
    end

    assign alloc.freeMask = ~busy;

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            issue.readyMask[i] = busy[i] && entries[i].src1.valid && entries[i].src2.valid;
        end
    end

    assign issue.grantEntry = entries[issue.grantIndex];

    // select may only pick an occupied entry with both operands in
    assert property (@(posedge clk) disable iff (reset)
        issue.grantFire |-> busy[issue.grantIndex] && issue.readyMask[issue.grantIndex])
        else $error("grant of entry %0d that is not ready", issue.grantIndex);

endmodule

/* hdl/rsIssueSelect.sv */
module rsIssueSelect import rsPkg::*; #(
    parameter int NUM_ENTRIES = 8
) (
    input logic clk,
    input logic reset,
    rsIssueIf.select issue,
    output logic issueValid,
    input logic issueReady,
    output logic [DATA_WIDTH-1:0] issuePc,
    output logic [TAG_WIDTH-1:0] issueDest,
    output rsCtrl_t issueCtrl,
    output logic [DATA_WIDTH-1:0] issueImm,
    output logic [DATA_WIDTH-1:0] issueSrc1Data,
    output logic [DATA_WIDTH-1:0] issueSrc2Data
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    logic canLoad;

    assign canLoad = !issueValid || issueReady; // register empty or draining
    assign issue.grantIndex = IDX_W'(lowestSet(MAX_ENTRIES'(issue.readyMask)));
    assign issue.grantFire = canLoad && (|issue.readyMask);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issueValid <= 1'b0;
        end else if (canLoad) begin
            issueValid <= |issue.readyMask;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.grantFire) begin
            issuePc <= issue.grantEntry.pc;
            issueDest <= issue.grantEntry.dest;
            issueCtrl <= issue.grantEntry.ctrl;
            issueImm <= issue.grantEntry.imm;
            issueSrc1Data <= issue.grantEntry.src1.data;
            issueSrc2Data <= issue.grantEntry.src2.data;
        end
    end

    // loaded entry must carry both operand values
    assert property (@(posedge clk) disable iff (reset)
        issue.grantFire |-> issue.grantEntry.src1.valid && issue.grantEntry.src2.valid)
        else $error("grant of entry %0d with a missing operand", issue.grantIndex);

endmodule

/* hdl/rsTop.sv */
module rsTop import rsPkg::*; #(
    parameter int NUM_ENTRIES = 8,
    parameter int NUM_BUSES = 4
) (
    input logic clk,
    input logic reset,
    input logic dispatchValid,
    output logic dispatchReady,
    input logic [DATA_WIDTH-1:0] dispatchPc,
    input logic [TAG_WIDTH-1:0] dispatchDest,
    input rsCtrl_t dispatchCtrl,
    input logic [DATA_WIDTH-1:0] dispatchImm,
    input rsOperand_t src1,
    input rsOperand_t src2,
    input rsBus_t buses [NUM_BUSES],
    output logic issueValid,
    input logic issueReady,
    output logic [DATA_WIDTH-1:0] issuePc,
    output logic [TAG_WIDTH-1:0] issueDest,
    output rsCtrl_t issueCtrl,
    output logic [DATA_WIDTH-1:0] issueImm,
    output logic [DATA_WIDTH-1:0] issueSrc1Data,
    output logic [DATA_WIDTH-1:0] issueSrc2Data
);

    rsAllocIf #(.NUM_ENTRIES(NUM_ENTRIES)) allocBus ();
    rsIssueIf #(.NUM_ENTRIES(NUM_ENTRIES)) issueBus ();

    rsDispatch #(
        .NUM_ENTRIES(NUM_ENTRIES),
        .NUM_BUSES(NUM_BUSES)
    ) dispatchStage (
        .clk(clk),
        .reset(reset),
        .dispatchValid(dispatchValid),
        .dispatchReady(dispatchReady),
        .dispatchPc(dispatchPc),
        .dispatchDest(dispatchDest),
        .dispatchCtrl(dispatchCtrl),
        .dispatchImm(dispatchImm),
        .src1(src1),
        .src2(src2),
        .buses(buses),
        .alloc(allocBus.dispatch)
    );

    rsEntryTable #(
        .NUM_ENTRIES(NUM_ENTRIES),
        .NUM_BUSES(NUM_BUSES)
    ) entryTable (
        .clk(clk),
        .reset(reset),
        .buses(buses),
        .alloc(allocBus.storage),
        .issue(issueBus.storage)
    );

    rsIssueSelect #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) issueStage (
        .clk(clk),
        .reset(reset),
        .issue(issueBus.select),
        .issueValid(issueValid),
        .issueReady(issueReady),
        .issuePc(issuePc),
        .issueDest(issueDest),
        .issueCtrl(issueCtrl),
        .issueImm(issueImm),
        .issueSrc1Data(issueSrc1Data),
        .issueSrc2Data(issueSrc2Data)
    );

endmodule

/* testbench/rsTbModel.svh */
typedef struct packed {
    logic [TAG_WIDTH-1:0] dest;
    rsCtrl_t ctrl;
    logic [DATA_WIDTH-1:0] imm;
    logic [1:0] pending; // source waited for a broadcast
    logic [1:0][TAG_WIDTH-1:0] tag;
    logic [1:0][DATA_WIDTH-1:0] data; // value the source must issue with
} expectedOp_t;

expectedOp_t expected [logic [DATA_WIDTH-1:0]];
logic [DATA_WIDTH-1:0] tagValue [logic [TAG_WIDTH-1:0]];
bit tagSent [logic [TAG_WIDTH-1:0]];
logic [TAG_WIDTH-1:0] pendingTags [$]; // dispatched, not yet broadcast
logic [TAG_WIDTH-1:0] nextTag = 1;
int numAccepted = 0;
int numIssued = 0;

// each producer tag is handed out once, with its own value
function automatic logic [TAG_WIDTH-1:0] newTag(logic [DATA_WIDTH-1:0] value);
    logic [TAG_WIDTH-1:0] tag;
    tag = nextTag;
    nextTag = nextTag + 1'b1;
    tagValue[tag] = value;
    return tag;
endfunction

function automatic logic [DATA_WIDTH-1:0] nextPc();
    return 32'h1000 + DATA_WIDTH'(numAccepted) * 4; // unique per micro-op
endfunction

function automatic void recordOp(logic [DATA_WIDTH-1:0] pc, expectedOp_t op);
    expected[pc] = op;
    numAccepted++;
endfunction

function automatic void retireOp(logic [DATA_WIDTH-1:0] pc);
    expected.delete(pc);
    numIssued++;
endfunction

/* testbench/rsTb.sv */
module rsTb import rsPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ENTRIES = 8;
    localparam int NUM_BUSES = 4;
    localparam int RANDOM_OPS = 40;
    localparam int WAIT_LIMIT = 2000;
    localparam int CTRL_W = $bits(rsCtrl_t);

    logic clk;
    logic reset;
    logic dispatchValid;
    logic dispatchReady;
    logic [DATA_WIDTH-1:0] dispatchPc;
    logic [TAG_WIDTH-1:0] dispatchDest;
    rsCtrl_t dispatchCtrl;
    logic [DATA_WIDTH-1:0] dispatchImm;
    rsOperand_t src1;
    rsOperand_t src2;
    rsBus_t buses [NUM_BUSES];
    logic issueValid;
    logic issueReady;
    logic [DATA_WIDTH-1:0] issuePc;
    logic [TAG_WIDTH-1:0] issueDest;
    rsCtrl_t issueCtrl;
    logic [DATA_WIDTH-1:0] issueImm;
    logic [DATA_WIDTH-1:0] issueSrc1Data;
    logic [DATA_WIDTH-1:0] issueSrc2Data;

    integer seed;
    int readyPercent;
    int busPercent;
    bit broadcastOn; // pending tags may go out on the buses
    bit stalled;
    logic [159:0] heldOut;

    `include "rsTbModel.svh"

    rsTop #(
        .NUM_ENTRIES(NUM_ENTRIES),
        .NUM_BUSES(NUM_BUSES)
    ) DUT (
        .clk(clk),
        .reset(reset),
        .dispatchValid(dispatchValid),
        .dispatchReady(dispatchReady),
        .dispatchPc(dispatchPc),
        .dispatchDest(dispatchDest),
        .dispatchCtrl(dispatchCtrl),
        .dispatchImm(dispatchImm),
        .src1(src1),
        .src2(src2),
        .buses(buses),
        .issueValid(issueValid),
        .issueReady(issueReady),
        .issuePc(issuePc),
        .issueDest(issueDest),
        .issueCtrl(issueCtrl),
        .issueImm(issueImm),
        .issueSrc1Data(issueSrc1Data),
        .issueSrc2Data(issueSrc2Data)
    );

    always #5 clk = ~clk;

    function automatic int randBelow(int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    task automatic checkValue(input string name, input logic [159:0] actual,
                              input logic [159:0] want);
        if (actual !== want) begin
            $display("TEST FAILED");
            $display("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, want);
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic failRun(input string what);
        $display("TEST FAILED");
        $display("ERROR at %0t ns: %s", $time, what);
        $fatal(1, "run stopped");
    endtask

    task automatic checkIssue();
        expectedOp_t op;
        if (!expected.exists(issuePc)) begin
            failRun($sformatf("pc 0x%0h issued but is not outstanding", issuePc));
        end
        op = expected[issuePc];
        for (int s = 0; s < 2; s++) begin
            if (op.pending[s]) begin
                checkValue("source tag broadcast", tagSent.exists(op.tag[s]), 1);
            end
        end
        checkValue("issueDest", issueDest, op.dest);
        checkValue("issueCtrl", issueCtrl, op.ctrl);
        checkValue("issueImm", issueImm, op.imm);
        checkValue("issueSrc1Data", issueSrc1Data, op.data[0]);
        checkValue("issueSrc2Data", issueSrc2Data, op.data[1]);
    endtask

    // issue side, sampled at the falling edge
    task automatic watchIssue();
        if (stalled) begin
            checkValue("issueValid", issueValid, 1);
            checkValue("issue outputs", {issuePc, issueDest, issueCtrl, issueImm,
                                         issueSrc1Data, issueSrc2Data}, heldOut);
        end else if (issueValid) begin
            checkIssue();
        end
        heldOut = {issuePc, issueDest, issueCtrl, issueImm, issueSrc1Data, issueSrc2Data};
        issueReady = randBelow(100) < readyPercent;
        stalled = issueValid && !issueReady;
        if (issueValid && issueReady) begin
            retireOp(issuePc);
        end
    endtask

    task automatic sendTag(input int b, input logic [TAG_WIDTH-1:0] tag);
        buses[b].valid = 1'b1;
        buses[b].tag = tag;
        buses[b].data = tagValue[tag];
        tagSent[tag] = 1'b1;
    endtask

    task automatic dispatchNew(input int pendPercent);
        expectedOp_t op;
        rsOperand_t srcs [2];
        int freeBus;
        if (nextTag > 7'd120) begin
            failRun("ran out of unique producer tags");
        end
        op.dest = TAG_WIDTH'($random(seed));
        op.ctrl = CTRL_W'($random(seed));
        op.imm = $random(seed);
        for (int s = 0; s < 2; s++) begin
            op.data[s] = $random(seed);
            if (randBelow(100) < pendPercent) begin
                op.pending[s] = 1'b1;
                op.tag[s] = newTag(op.data[s]);
                srcs[s] = {op.tag[s], DATA_WIDTH'($random(seed)), 1'b0}; // stale data
                freeBus = -1;
                for (int b = NUM_BUSES - 1; b >= 0; b--) begin
                    if (!buses[b].valid) freeBus = b;
                end
                if (broadcastOn && freeBus >= 0 && randBelow(100) < 25) begin
                    sendTag(freeBus, op.tag[s]); // same-cycle capture
                end else begin
                    pendingTags.push_back(op.tag[s]);
                end
            end else begin
                op.pending[s] = 1'b0;
                op.tag[s] = TAG_WIDTH'($random(seed));
                srcs[s] = {op.tag[s], op.data[s], 1'b1};
            end
        end
        dispatchValid = 1'b1;
        dispatchPc = nextPc();
        dispatchDest = op.dest;
        dispatchCtrl = op.ctrl;
        dispatchImm = op.imm;
        src1 = srcs[0];
        src2 = srcs[1];
        recordOp(dispatchPc, op); // ready is high, so this edge accepts
    endtask

    // one clock of stimulus, from one falling edge to the next
    task automatic driveCycle(input int dispatchPercent, input int pendPercent);
        int k;
        logic [TAG_WIDTH-1:0] tag;
        watchIssue();
        dispatchValid = 1'b0;
        for (int i = 0; i < NUM_BUSES; i++) begin
            buses[i].valid = 1'b0;
            buses[i].tag = TAG_WIDTH'($random(seed)); // idle noise
            buses[i].data = $random(seed);
            if (broadcastOn && pendingTags.size() > 0 && randBelow(100) < busPercent) begin
                k = randBelow(pendingTags.size());
                tag = pendingTags[k];
                pendingTags.delete(k);
                sendTag(i, tag);
            end
        end
        if (dispatchReady && randBelow(100) < dispatchPercent) begin
            dispatchNew(pendPercent);
        end
        @(negedge clk);
    endtask

    task automatic drainAll();
        int waited;
        waited = 0;
        while (numIssued < numAccepted) begin
            if (waited == WAIT_LIMIT) failRun("outstanding micro-ops did not all issue");
            driveCycle(0, 0);
            waited++;
        end
    endtask

    initial begin
        int waited;
        int fillTarget;
        seed = 32'hdcdee488;
        clk = 1'b0;
        reset = 1'b1;
        dispatchValid = 1'b0;
        dispatchPc = '0;
        dispatchDest = '0;
        dispatchCtrl = '0;
        dispatchImm = '0;
        src1 = '0;
        src2 = '0;
        issueReady = 1'b0;
        for (int i = 0; i < NUM_BUSES; i++) begin
            buses[i] = '0;
        end
        broadcastOn = 1'b1;
        readyPercent = 60;
        busPercent = 40;
        stalled = 1'b0;
        heldOut = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        checkValue("issueValid", issueValid, 0);
        checkValue("dispatchReady", dispatchReady, 1);

        waited = 0;
        while (numAccepted < RANDOM_OPS) begin
            if (waited == WAIT_LIMIT) failRun("random micro-ops were not all accepted");
            driveCycle(70, 50);
            waited++;
        end
        drainAll();

        // fill every entry with operands that stay missing
        readyPercent = 100;
        broadcastOn = 1'b0;
        fillTarget = numAccepted + NUM_ENTRIES;
        waited = 0;
        while (numAccepted < fillTarget) begin
            if (waited == WAIT_LIMIT) failRun("table did not take a full load of micro-ops");
            driveCycle(100, 100);
            waited++;
        end
        repeat (20) begin
            driveCycle(100, 100);
            checkValue("dispatchReady", dispatchReady, 0);
            checkValue("issueValid", issueValid, 0);
        end
        broadcastOn = 1'b1;
        drainAll();
        repeat (NUM_ENTRIES) begin
            driveCycle(0, 0);
            checkValue("issueValid", issueValid, 0); // nothing left to issue
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* src.f */
+incdir+testbench
hdl/rsPkg.sv
hdl/rsAllocIf.sv
hdl/rsIssueIf.sv
hdl/rsDispatch.sv
hdl/rsEntryTable.sv
hdl/rsIssueSelect.sv
hdl/rsTop.sv
testbench/rsTb.sv

/* Bender.yml */
package:
  name: rs_station

sources:
  - files:
      - hdl/rsPkg.sv
      - hdl/rsAllocIf.sv
      - hdl/rsIssueIf.sv
      - hdl/rsDispatch.sv
      - hdl/rsEntryTable.sv
      - hdl/rsIssueSelect.sv
      - hdl/rsTop.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/rsTb.sv
